/* bench/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb import cpu_pkg::*; ();

   logic                  clk;
   logic                  arst_n;
   logic                  load;
   logic [mem_addr_w-1:0] load_addr;
   logic [xlen-1:0]       load_data;
   logic                  retire;
   retire_t               retire_info;
   logic                  halted;

   // Parsed test data with each record tagged by its test index
   string           names[$];
   int              l_owner[$];
   logic [xlen-1:0] l_addr[$];
   logic [xlen-1:0] l_data[$];
   int              e_owner[$];
   retire_t         e_val[$];

   int cycle_cnt   = 0;
   int start_cycle = 0;
   int cycle_limit = 100;
   int n_pass      = 0;
   int n_fail      = 0;
   int n_errors    = 0;

   cpu i_cpu (
      .clk         (clk),
      .arst_n      (arst_n),
      .load        (load),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .retire      (retire),
      .retire_info (retire_info),
      .halted      (halted)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Watchdog with a limit set per test
   initial begin
      while (cycle_cnt - start_cycle <= cycle_limit) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: the core did not halt within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
   end

   function automatic int check_field(input string name, input logic [xlen-1:0] expv,
                                      input logic [xlen-1:0] actv);
      int bad;
      bad = 0;
      assert (actv === expv) else begin
         $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expv, actv);
         bad = 1;
      end
      return bad;
   endfunction

   task automatic read_testdata();
      int              fd;
      string           line;
      string           name;
      logic [xlen-1:0] f1;
      logic [xlen-1:0] f2;
      logic [xlen-1:0] f3;
      logic [xlen-1:0] f4;
      retire_t         r;
      fd = $fopen("bench/cpu_testdata.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the test data file bench/cpu_testdata.txt");
         return;
      end
      while ($fgets(line, fd) != 0) begin
         if ($sscanf(line, "T %s", name) == 1) begin
            names.push_back(name);
         end else if ($sscanf(line, "L %h %h", f1, f2) == 2) begin
            l_owner.push_back(names.size() - 1);
            l_addr.push_back(f1);
            l_data.push_back(f2);
         end else if ($sscanf(line, "E %h %h %h %h", f1, f2, f3, f4) == 4) begin
            r.pc      = f1;
            r.wb_en   = f2[0];
            r.wb_reg  = f3[reg_addr_w-1:0];
            r.wb_data = f4;
            e_owner.push_back(names.size() - 1);
            e_val.push_back(r);
         end
      end
      $fclose(fd);
   endtask

   task automatic run_test(input int t);
      retire_t exp_cur[$];
      int      n_load;
      int      pos;
      int      errs;
      bit      done;
      bit      expect_halt;
      n_load      = 0;
      pos         = 0;
      errs        = 0;
      done        = 1'b0;
      expect_halt = 1'b0;
      foreach (e_owner[i]) begin
         if (e_owner[i] == t) exp_cur.push_back(e_val[i]);
      end
      foreach (l_owner[i]) begin
         if (l_owner[i] == t) n_load++;
      end
      @(negedge clk);
      start_cycle = cycle_cnt;
      cycle_limit = n_load + 5 * exp_cur.size() + 50;

      @(posedge clk);
      arst_n <= 1'b0;
      load   <= 1'b0;
      repeat (8) @(posedge clk);
      arst_n <= 1'b1;
      // Program goes in while the core sits in idle
      foreach (l_owner[i]) begin
         if (l_owner[i] == t) begin
            load      <= 1'b1;
            load_addr <= l_addr[i][mem_addr_w-1:0];
            load_data <= l_data[i];
            @(posedge clk);
         end
      end
      load <= 1'b0;

      while (!done) begin
         @(negedge clk);
         // Halted follows the last retirement by one cycle
         if (expect_halt) begin
            assert (halted) else begin
               $display("Core did not halt in the cycle after its last retirement at %0t ns",
                        $time);
               errs++;
            end
         end
         expect_halt = retire && (pos == exp_cur.size() - 1);
         if (retire) begin
            assert (pos < exp_cur.size()) else begin
               $display("Unexpected extra retirement at %0t ns from pc %h",
                        $time, retire_info.pc);
               errs++;
            end
            if (pos < exp_cur.size()) begin
               errs += check_field("retire_info.pc", exp_cur[pos].pc, retire_info.pc);
               errs += check_field("retire_info.wb_en", exp_cur[pos].wb_en,
                                   retire_info.wb_en);
               // Register and data only mean something on a write
               if (exp_cur[pos].wb_en) begin
                  errs += check_field("retire_info.wb_reg", exp_cur[pos].wb_reg,
                                      retire_info.wb_reg);
                  errs += check_field("retire_info.wb_data", exp_cur[pos].wb_data,
                                      retire_info.wb_data);
               end
            end
            pos++;
         end
         done = halted;
      end
      assert (pos == exp_cur.size()) else begin
         $display("Core halted after %0d of %0d expected retirements", pos, exp_cur.size());
         errs++;
      end
      repeat (5) begin
         @(negedge clk);
         assert (halted && !retire) else begin
            $display("Core left the halted state or retired again at %0t ns", $time);
            errs++;
         end
      end

      if (errs == 0) begin
         $display("%s: pass", names[t]);
         n_pass++;
      end else begin
         $display("%s: FAIL with %0d errors", names[t], errs);
         n_fail++;
      end
      n_errors += errs;
   endtask

   initial begin
      arst_n    = 1'b0;
      load      = 1'b0;
      load_addr = '0;
      load_data = '0;
      read_testdata();
      foreach (names[t]) begin
         run_test(t);
      end
      $display("%0d tests run: %0d passed, %0d failed, %0d errors",
               names.size(), n_pass, n_fail, n_errors);
      if (n_fail == 0 && names.size() > 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* bench/cpu_testdata.txt */
# T name starts a test; L word_addr instr_word loads memory (hex)
# E pc wb_en wb_reg wb_data is one expected retirement, in order (hex)
T alu
L 000 0840FFF8
L 001 08800003
L 002 20C22000
L 003 21022001
L 004 21422002
L 005 21822003
L 006 21C22004
L 007 22022005
L 008 22422006
L 009 22822007
L 00A 30000000
E 000 1 01 FFFFFFF8
E 001 1 02 00000003
E 002 1 03 FFFFFFFB
E 003 1 04 FFFFFFF5
E 004 1 05 00000000
E 005 1 06 FFFFFFFB
E 006 1 07 FFFFFFFB
E 007 1 08 FFFFFFC0
E 008 1 09 1FFFFFFF
E 009 1 0A 00000001
E 00A 0 00 00000000
T store_load
L 000 08400100
L 001 0880ABCD
L 002 18022000
L 003 10C20000
L 004 30000000
E 000 1 01 00000100
E 001 1 02 FFFFABCD
E 002 0 00 00000000
E 003 1 03 FFFFABCD
E 004 0 00 00000000
T jump
L 000 08800004
L 001 28002000
L 002 28042000
L 003 08C00001
L 004 30000000
E 000 1 02 00000004
E 001 0 00 00000000
E 002 0 00 00000000
E 004 0 00 00000000
T illegal
L 000 08400007
L 001 38000000
E 000 1 01 00000007
E 001 0 00 00000000

/* cpu.f */
hdl/cpu_pkg.sv
hdl/stage_sequencer.sv
hdl/instr_decoder.sv
hdl/alu.sv
hdl/register_file.sv
hdl/fetch_unit.sv
hdl/main_memory.sv
hdl/cpu.sv
bench/cpu_tb.sv

/* hdl/alu.sv */
`timescale 1ns/10ps

module alu import cpu_pkg::*; (
   input  logic [xlen-1:0] a,
   input  logic [xlen-1:0] b,
   input  alu_func_t       func,
   output logic [xlen-1:0] result
);

   logic [4:0] shamt;

   assign shamt = b[4:0];

   always_comb begin
      case (func)
         ADD: result = a + b;
         SUB: result = a - b;
         AND: result = a & b;
         OR:  result = a | b;
         XOR: result = a ^ b;
         SHL: result = a << shamt;
         SHR: result = a >> shamt;
         SLT: begin
            result = ($signed(a) < $signed(b)) ? xlen'(1) : '0;
         end
         default: result = '0;
      endcase
   end

endmodule

/* hdl/cpu.sv */
`timescale 1ns/10ps

module cpu import cpu_pkg::*; (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  load,
   input  logic [mem_addr_w-1:0] load_addr,
   input  logic [xlen-1:0]       load_data,
   output logic                  retire,
   output retire_t               retire_info,
   output logic                  halted
);

   stage_t          stage;
   decoded_t        dec;
   logic            halt_req;
   logic [xlen-1:0] pc;
   logic [xlen-1:0] instr;
   logic [xlen-1:0] mem_rdata;
   logic [xlen-1:0] opnd_a;
   logic [xlen-1:0] opnd_b;
   logic [xlen-1:0] alu_result;
   logic            wb_en;
   logic [xlen-1:0] wb_data;

   // Illegal opcodes stop the core like HALT
   assign halt_req = (dec.op == OP_HALT) || dec.illegal;

   stage_sequencer i_stage_sequencer (
      .clk      (clk),
      .arst_n   (arst_n),
      .load     (load),
      .halt_req (halt_req),
      .stage    (stage),
      .halted   (halted)
   );

   fetch_unit i_fetch_unit (
      .clk       (clk),
      .arst_n    (arst_n),
      .stage     (stage),
      .dec       (dec),
      .mem_rdata (mem_rdata),
      .opnd_a    (opnd_a),
      .opnd_b    (opnd_b),
      .pc        (pc),
      .instr     (instr)
   );

   instr_decoder i_instr_decoder (
      .instr (instr),
      .dec   (dec)
   );

   register_file i_register_file (
      .clk        (clk),
      .arst_n     (arst_n),
      .stage      (stage),
      .dec        (dec),
      .alu_result (alu_result),
      .mem_rdata  (mem_rdata),
      .opnd_a     (opnd_a),
      .opnd_b     (opnd_b),
      .wb_en      (wb_en),
      .wb_data    (wb_data)
   );

   alu i_alu (
      .a      (opnd_a),
      .b      (opnd_b),
      .func   (dec.func),
      .result (alu_result)
   );

   main_memory i_main_memory (
      .clk       (clk),
      .load      (load),
      .stage     (stage),
      .dec       (dec),
      .load_addr (load_addr),
      .load_data (load_data),
      .pc        (pc),
      .opnd_a    (opnd_a),
      .opnd_b    (opnd_b),
      .rdata     (mem_rdata)
   );

   // One retire per instruction, in its writeback cycle
   assign retire = (stage == ST_WRITEBACK);

   always_comb begin
      retire_info.pc      = pc;
      retire_info.wb_en   = wb_en;
      retire_info.wb_reg  = dec.rd;
      retire_info.wb_data = wb_data;
   end

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

   localparam int xlen       = 32;
   localparam int reg_count  = 32;
   localparam int reg_addr_w = 5;
   localparam int mem_depth  = 2048;
   localparam int mem_addr_w = 11;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_FETCH,
      ST_ISSUE,
      ST_READ,
      ST_EXECUTE,
      ST_WRITEBACK,
      ST_HALTED
   } stage_t;

   // Code 0 is left illegal so that a blank word stops the core
   typedef enum logic [4:0] {
      OP_LOAD_IMM = 5'd1,
      OP_LOAD_MEM = 5'd2,
      OP_STORE    = 5'd3,
      OP_ALU      = 5'd4,
      OP_JUMP_NZ  = 5'd5,
      OP_HALT     = 5'd6
   } opcode_t;

   typedef enum logic [2:0] {
      ADD,
      SUB,
      AND,
      OR,
      XOR,
      SHL,
      SHR,
      SLT
   } alu_func_t;

   typedef struct packed {
      opcode_t                op;
      logic [reg_addr_w-1:0]  rd;
      logic [reg_addr_w-1:0]  ra;
      logic [reg_addr_w-1:0]  rb;
      alu_func_t              func;
      logic [xlen-1:0]        imm;
      logic                   illegal;
   } decoded_t;

   typedef struct packed {
      logic [xlen-1:0]        pc;
      logic                   wb_en;
      logic [reg_addr_w-1:0]  wb_reg;
      logic [xlen-1:0]        wb_data;
   } retire_t;

endpackage

/* hdl/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit import cpu_pkg::*; (
   input  logic            clk,
   input  logic            arst_n,
   input  stage_t          stage,
   input  decoded_t        dec,
   input  logic [xlen-1:0] mem_rdata,
   input  logic [xlen-1:0] opnd_a,
   input  logic [xlen-1:0] opnd_b,
   output logic [xlen-1:0] pc,
   output logic [xlen-1:0] instr
);

   logic [xlen-1:0] pc_nxt;
   logic            take_jump;

   // Condition in ra, target in rb
   assign take_jump = (dec.op == OP_JUMP_NZ) && (opnd_a != '0);
   assign pc_nxt    = take_jump ? opnd_b : pc + xlen'(1);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc    <= '0;
         instr <= '0;
      end else begin
         if (stage == ST_ISSUE) begin
            instr <= mem_rdata;
         end
         if (stage == ST_WRITEBACK) begin
            pc <= pc_nxt;
         end
      end
   end

   // A jump past the end of memory is a program error
   a_pc_in_range: assert property (@(posedge clk) disable iff (!arst_n)
      (stage != ST_IDLE) |-> (pc < mem_depth));

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder import cpu_pkg::*; (
   input  logic [xlen-1:0] instr,
   output decoded_t        dec
);

   logic [4:0] op_bits;

   assign op_bits = instr[31:27];

   always_comb begin
      dec.op   = opcode_t'(op_bits);
      dec.rd   = instr[26:22];
      dec.ra   = instr[21:17];
      dec.rb   = instr[16:12];
      dec.func = alu_func_t'(instr[2:0]);
      // Immediate is sign-extended from 16 bits
      dec.imm  = {{(xlen-16){instr[15]}}, instr[15:0]};

      case (op_bits)
         OP_LOAD_IMM,
         OP_LOAD_MEM,
         OP_STORE,
         OP_ALU,
         OP_JUMP_NZ,
         OP_HALT: begin
            dec.illegal = 1'b0;
         end
         default: begin
            dec.illegal = 1'b1;
         end
      endcase
   end

endmodule

/* hdl/main_memory.sv */
`timescale 1ns/10ps

module main_memory import cpu_pkg::*; (
   input  logic                  clk,
   input  logic                  load,
   input  stage_t                stage,
   input  decoded_t              dec,
   input  logic [mem_addr_w-1:0] load_addr,
   input  logic [xlen-1:0]       load_data,
   input  logic [xlen-1:0]       pc,
   input  logic [xlen-1:0]       opnd_a,
   input  logic [xlen-1:0]       opnd_b,
   output logic [xlen-1:0]       rdata
);

   logic [xlen-1:0]       mem [mem_depth];
   logic [mem_addr_w-1:0] raddr;
   logic [mem_addr_w-1:0] waddr;
   logic [xlen-1:0]       wdata;
   logic                  we;

   // Data address in EXECUTE, instruction address otherwise
   always_comb begin
      if (stage == ST_EXECUTE) begin
         raddr = opnd_a[mem_addr_w-1:0];
      end else begin
         raddr = pc[mem_addr_w-1:0];
      end
   end

   always_comb begin
      we    = 1'b0;
      waddr = load_addr;
      wdata = load_data;
      case (stage)
         ST_IDLE: begin
            we = load;
         end
         ST_EXECUTE: begin
            we    = (dec.op == OP_STORE);
            waddr = opnd_a[mem_addr_w-1:0];
            wdata = opnd_b;
         end
         default: begin
            we = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
      rdata <= mem[raddr];
   end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/10ps

module register_file import cpu_pkg::*; (
   input  logic            clk,
   input  logic            arst_n,
   input  stage_t          stage,
   input  decoded_t        dec,
   input  logic [xlen-1:0] alu_result,
   input  logic [xlen-1:0] mem_rdata,
   output logic [xlen-1:0] opnd_a,
   output logic [xlen-1:0] opnd_b,
   output logic            wb_en,
   output logic [xlen-1:0] wb_data
);

   logic [reg_count-1:0][xlen-1:0] regs;
   logic                           reg_we;

   // Writeback source by opcode
   always_comb begin
      wb_en   = 1'b0;
      wb_data = '0;
      case (dec.op)
         OP_LOAD_IMM: begin
            wb_en   = 1'b1;
            wb_data = dec.imm;
         end
         OP_LOAD_MEM: begin
            wb_en   = 1'b1;
            wb_data = mem_rdata;
         end
         OP_ALU: begin
            wb_en   = 1'b1;
            wb_data = alu_result;
         end
         default: begin
            wb_en   = 1'b0;
            wb_data = '0;
         end
      endcase
   end

   assign reg_we = (stage == ST_WRITEBACK) && wb_en;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         regs   <= '0;
         opnd_a <= '0;
         opnd_b <= '0;
      end else begin
         if (reg_we) begin
            regs[dec.rd] <= wb_data;
         end
         // Operands hold until the next READ
         if (stage == ST_READ) begin
            opnd_a <= regs[dec.ra];
            opnd_b <= regs[dec.rb];
         end
      end
   end

   a_write_in_writeback: assert property (@(posedge clk) disable iff (!arst_n)
      (stage != ST_WRITEBACK) |=> $stable(regs));

endmodule

/* hdl/stage_sequencer.sv */
`timescale 1ns/10ps

module stage_sequencer import cpu_pkg::*; (
   input  logic   clk,
   input  logic   arst_n,
   input  logic   load,
   input  logic   halt_req,
   output stage_t stage,
   output logic   halted
);

   stage_t stage_nxt;

   always_comb begin
      stage_nxt = stage;
      case (stage)
         ST_IDLE:      if (!load) stage_nxt = ST_FETCH;
         ST_FETCH:     stage_nxt = ST_ISSUE;
         ST_ISSUE:     stage_nxt = ST_READ;
         ST_READ:      stage_nxt = ST_EXECUTE;
         ST_EXECUTE:   stage_nxt = ST_WRITEBACK;
         ST_WRITEBACK: stage_nxt = halt_req ? ST_HALTED : ST_FETCH;
         ST_HALTED:    stage_nxt = ST_HALTED;
         default:      stage_nxt = ST_HALTED;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         stage <= ST_IDLE;
      end else begin
         stage <= stage_nxt;
      end
   end

   assign halted = (stage == ST_HALTED);

   // Program load only while the core is not running
   a_load_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
      load |-> (stage inside {ST_IDLE, ST_HALTED}));

endmodule
